// File: design/main_memory.sv
// word memory with two-cycle reads
`timescale 1ns/1ps

module main_memory #(
    parameter int unsigned MEM_WORDS_LOG2 = 14
) (
    input  logic              clk,
    input  logic              rst_n,

    // request port
    input  sv32_pkg::mem_req_t req,
    output logic              req_ready,
    output sv32_pkg::mem_rsp_t rsp,

    // host load port
    input  logic              load_en,
    input  sv32_pkg::word_t    load_addr,
    input  sv32_pkg::word_t    load_data
);

    import sv32_pkg::*;

    localparam int unsigned DEPTH = 1 << MEM_WORDS_LOG2;

    // word index, upper address bits wrap
    typedef logic [MEM_WORDS_LOG2-1:0] widx_t;

    word_t mem_array [DEPTH];

    widx_t req_idx;
    widx_t load_idx;
    widx_t rd_idx;

    // read pipeline
    // stage 1 holds the index, stage 2 the data
    logic  rd_pend;
    logic  rsp_valid;
    word_t rsp_data;

    logic  req_fire;
    logic  rd_fire;

    // byte address to word index
    assign req_idx  = req.addr[MEM_WORDS_LOG2+1:2];
    assign load_idx = load_addr[MEM_WORDS_LOG2+1:2];

    // blocked while any read is in flight
    assign req_ready = !rd_pend && !rsp_valid;
    assign req_fire  = req.valid && req_ready;
    assign rd_fire   = req_fire && !req.wen;

    assign rsp.valid = rsp_valid;
    assign rsp.rdata = rsp_data;

    // array writes
    always_ff @(posedge clk) begin
        if (req_fire && req.wen) begin
            mem_array[req_idx] <= req.wdata;
        end
        // host load last, wins on the same word
        if (load_en) begin
            mem_array[load_idx] <= load_data;
        end
    end

    // pipeline valids
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rd_pend   <= rd_fire;
            rsp_valid <= rd_pend;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_idx <= req_idx;
        end
        // array read in the second cycle
        if (rd_pend) begin
            rsp_data <= mem_array[rd_idx];
        end
    end

    // an accepted read blocks the port and answers two edges later
    assert property (@(posedge clk) disable iff (!rst_n)
        (req.valid && req_ready && !req.wen)
        |=> !req_ready ##1 (rsp.valid && !req_ready))
        else $error("read pipeline overlap or late response");

endmodule

// File: design/page_table_walker.sv
// Sv32 page table walker
`timescale 1ns/1ps

module page_table_walker #(
    parameter int unsigned PTE_SIZE_LOG2 = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              kill,

    // requester side
    input  sv32_pkg::mem_req_t preq,
    output logic              preq_ready,
    output sv32_pkg::mem_rsp_t presp,

    // memory side
    output sv32_pkg::mem_req_t memreq,
    input  logic              memreq_ready,
    input  sv32_pkg::mem_rsp_t memresp,

    // csr view
    input  sv32_pkg::mode_t    csr_mode,
    input  sv32_pkg::word_t    csr_satp
);

    import sv32_pkg::*;

    // walk sequence, one memory access per REQ/WAIT pair
    typedef enum logic [2:0] {
        IDLE,
        WALK_REQ,
        WALK_WAIT,
        ACCESS_REQ,
        ACCESS_WAIT,
        DONE
    } state_t;

    state_t   state;

    // translation on outside machine mode with satp.mode set
    logic     sv32_en;

    // saved request and walk progress
    mem_req_t s_req;
    logic     level;
    paddr_t   next_addr;
    word_t    result_rdata;

    // fields of the saved virtual address
    vpn_t     s_vpn0;
    offset_t  s_offset;

    // fields of the returned pte
    ppn_t     resp_ppn;
    logic     resp_valid_pte;
    logic     resp_leaf;

    // walker-driven side of the muxes
    mem_req_t walk_req;
    mem_rsp_t walk_rsp;
    logic     walk_ready;

    assign sv32_en = (csr_mode != M_MODE) && satp_on(csr_satp);

    assign s_vpn0   = va_vpn0(s_req.addr);
    assign s_offset = va_offset(s_req.addr);

    assign resp_ppn       = pte_ppn(memresp.rdata);
    assign resp_valid_pte = memresp.rdata[PTE_V];
    assign resp_leaf      = pte_is_leaf(memresp.rdata);

    // accept only from IDLE
    assign walk_ready = (state == IDLE);

    // pte reads are always reads, only the final access may write
    assign walk_req.valid = (state == WALK_REQ) || (state == ACCESS_REQ);
    assign walk_req.wen   = (state == ACCESS_REQ) && s_req.wen;
    assign walk_req.addr  = next_addr[31:0];
    assign walk_req.wdata = s_req.wdata;

    // single pulse after the final access
    assign walk_rsp.valid = (state == DONE);
    assign walk_rsp.rdata = result_rdata;

    // bare mode goes straight through, no added cycles
    assign preq_ready = sv32_en ? walk_ready : memreq_ready;
    assign memreq     = sv32_en ? walk_req   : preq;
    assign presp      = sv32_en ? walk_rsp   : memresp;

    // walk state machine
    always_ff @(posedge clk) begin
        if (!rst_n || kill) begin
            state <= IDLE;
        end else if (sv32_en) begin
            case (state)
                IDLE: begin
                    if (preq.valid) begin
                        s_req     <= preq;
                        // start at level 1 from the root table
                        level     <= 1'b1;
                        next_addr <= table_addr(satp_ppn(csr_satp), va_vpn1(preq.addr),
                                                PTE_SIZE_LOG2);
                        state     <= WALK_REQ;
                    end
                end

                WALK_REQ: begin
                    // address held until the memory takes it
                    if (memreq_ready) begin
                        state <= WALK_WAIT;
                    end
                end

                WALK_WAIT: begin
                    if (memresp.valid) begin
                        if (!resp_valid_pte) begin
                            // invalid pte, access goes to 0
                            next_addr <= '0;
                            state     <= ACCESS_REQ;
                        end else if (resp_leaf) begin
                            if (level) begin
                                // megapage: ppn1, vpn0, offset
                                next_addr <= {resp_ppn[21:10], s_vpn0, s_offset};
                            end else begin
                                // 4K page: full ppn and offset
                                next_addr <= {resp_ppn, s_offset};
                            end
                            state <= ACCESS_REQ;
                        end else if (level) begin
                            // pointer, descend into the level-0 table
                            level     <= 1'b0;
                            next_addr <= table_addr(resp_ppn, s_vpn0, PTE_SIZE_LOG2);
                            state     <= WALK_REQ;
                        end else begin
                            // pointer at the last level is a failed walk
                            next_addr <= '0;
                            state     <= ACCESS_REQ;
                        end
                    end
                end

                ACCESS_REQ: begin
                    if (memreq_ready) begin
                        // writes get no memory response
                        state <= s_req.wen ? DONE : ACCESS_WAIT;
                    end
                end

                ACCESS_WAIT: begin
                    if (memresp.valid) begin
                        result_rdata <= memresp.rdata;
                        state        <= DONE;
                    end
                end

                DONE: begin
                    state <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a request accepted in IDLE never completes in the very next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (sv32_en && state == IDLE) ##1 sv32_en |-> !presp.valid)
        else $error("presp.valid raised straight out of IDLE");

    // stalled memory request keeps its address
    assert property (@(posedge clk) disable iff (!rst_n || kill)
        (sv32_en && memreq.valid && !memreq_ready) ##1 (sv32_en && !kill)
        |-> memreq.valid && $stable(memreq.addr))
        else $error("memreq.addr changed while waiting for ready");

endmodule

// File: design/ptw_subsystem.sv
// Sv32 translation subsystem
`timescale 1ns/1ps

module ptw_subsystem #(
    parameter int unsigned PTE_SIZE_LOG2  = 2,
    parameter int unsigned MEM_WORDS_LOG2 = 14
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              kill,

    // requester port
    input  sv32_pkg::mem_req_t preq,
    output logic              preq_ready,
    output sv32_pkg::mem_rsp_t presp,

    // csr state
    input  sv32_pkg::mode_t    csr_mode,
    input  sv32_pkg::word_t    csr_satp,

    // host load into memory
    input  logic              load_en,
    input  sv32_pkg::word_t    load_addr,
    input  sv32_pkg::word_t    load_data
);

    import sv32_pkg::*;

    // walker to memory
    mem_req_t memreq;
    logic     memreq_ready;
    mem_rsp_t memresp;

    page_table_walker #(
        .PTE_SIZE_LOG2 (PTE_SIZE_LOG2)
    ) page_table_walker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .kill         (kill),
        .preq         (preq),
        .preq_ready   (preq_ready),
        .presp        (presp),
        .memreq       (memreq),
        .memreq_ready (memreq_ready),
        .memresp      (memresp),
        .csr_mode     (csr_mode),
        .csr_satp     (csr_satp)
    );

    // serves pte reads and data accesses alike
    main_memory #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) main_memory_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (memreq),
        .req_ready (memreq_ready),
        .rsp       (memresp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: design/sv32_pkg.sv
// Sv32 translation types
package sv32_pkg;

    // data word and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [21:0] ppn_t;
    typedef logic [9:0]  vpn_t;
    typedef logic [11:0] offset_t;

    // privilege level as seen by the walker
    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        S_MODE = 2'd1,
        M_MODE = 2'd3
    } mode_t;

    // forward request, ready travels back on its own wire
    typedef struct packed {
        logic  valid;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // read response, one pulse per read
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_rsp_t;

    // pte flag and field positions
    localparam int unsigned PTE_V       = 0;
    localparam int unsigned PTE_R       = 1;
    localparam int unsigned PTE_X       = 3;
    localparam int unsigned PTE_PPN_LSB = 10;

    // satp.mode bit, sv32 on
    function automatic logic satp_on(word_t satp);
        return satp[31];
    endfunction

    // root table page number
    function automatic ppn_t satp_ppn(word_t satp);
        return satp[21:0];
    endfunction

    function automatic ppn_t pte_ppn(word_t pte);
        return pte[31:PTE_PPN_LSB];
    endfunction

    // valid pte with R or X set ends the walk
    function automatic logic pte_is_leaf(word_t pte);
        return pte[PTE_V] && (pte[PTE_R] || pte[PTE_X]);
    endfunction

    function automatic vpn_t va_vpn1(vaddr_t va);
        return va[31:22];
    endfunction

    function automatic vpn_t va_vpn0(vaddr_t va);
        return va[21:12];
    endfunction

    function automatic offset_t va_offset(vaddr_t va);
        return va[11:0];
    endfunction

    // entry address inside a table page
    function automatic paddr_t table_addr(ppn_t base, vpn_t vpn, int unsigned size_log2);
        return {base, 12'h000} + (paddr_t'(vpn) << size_log2);
    endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the walker testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ptw_tb \
    -f vlog.f \
    -o ptw_sim

./obj_dir/ptw_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"

// File: testbench/ptw_model.svh
// Sv32 reference model
`ifndef PTW_MODEL_SVH
`define PTW_MODEL_SVH

// pte flag fields as written into table entries
localparam logic [9:0] F_V = 10'(1 << PTE_V);
localparam logic [9:0] F_R = 10'(1 << PTE_R);
localparam logic [9:0] F_X = 10'(1 << PTE_X);

// table locations, all inside the wrapped 64 KiB image
localparam word_t ROOT_BASE = 32'h0000_8000;
localparam word_t L0_BASE   = 32'h0000_9000;
localparam word_t BAD_BASE  = 32'h0000_a000;

// shadow of the DUT memory
word_t shadow_mem [DEPTH];
word_t rng_state = 32'h1759;

// byte address to word index, same wrap as the memory
function automatic int unsigned word_index(input word_t addr);
    return (addr >> 2) & (DEPTH - 1);
endfunction

// odd multiplier keeps every word distinct
function automatic word_t fill_pattern(input int unsigned idx);
    word_t a;
    a = idx << 2;
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
endfunction

// xorshift32
function word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic translation_on();
    return (csr_mode != M_MODE) && csr_satp[31];
endfunction

function automatic word_t make_pte(input logic [21:0] ppn, input logic [9:0] flags);
    return {ppn, flags};
endfunction

// predicted physical address, low 32 bits
function automatic word_t translate(input word_t va);
    word_t pte;
    word_t pte_addr;
    if (!translation_on()) begin
        return va;
    end
    // level 1 lookup in the root table
    pte_addr = {csr_satp[19:0], 12'h000} + (32'(va[31:22]) << PTE_SIZE_LOG2);
    pte = shadow_mem[word_index(pte_addr)];
    if (!pte[PTE_V]) begin
        return '0;
    end
    if (pte[PTE_R] || pte[PTE_X]) begin
        // megapage, low bits of ppn1 then vpn0 and offset
        return {pte[29:20], va[21:0]};
    end
    pte_addr = {pte[29:10], 12'h000} + (32'(va[21:12]) << PTE_SIZE_LOG2);
    pte = shadow_mem[word_index(pte_addr)];
    if (pte[PTE_V] && (pte[PTE_R] || pte[PTE_X])) begin
        return {pte[29:10], va[11:0]};
    end
    // invalid entry or pointer at level 0
    return '0;
endfunction

// one word through the host port, mirrored in the shadow
task automatic load_word(input word_t addr, input word_t data);
    load_en   = 1'b1;
    load_addr = addr;
    load_data = data;
    shadow_mem[word_index(addr)] = data;
    @(posedge clk);
    #1;
    load_en = 1'b0;
endtask

task automatic fill_memory();
    for (int unsigned i = 0; i < DEPTH; i++) begin
        load_word(i << 2, fill_pattern(i));
    end
endtask

// vpn1 1 points to a level-0 table with four 4K leaves
task automatic build_4k_tables();
    load_word(ROOT_BASE + 32'd4, make_pte(22'h9, F_V));
    for (int unsigned i = 0; i < 4; i++) begin
        load_word(L0_BASE + (i << 2),
                  make_pte(22'(4 + i), F_V | ((i % 2 == 0) ? F_R : F_X)));
    end
endtask

// vpn1 2 is a readable megapage
task automatic build_megapage();
    load_word(ROOT_BASE + 32'd8, make_pte({12'h003, 10'h000}, F_V | F_R));
endtask

// vpn1 3 invalid at level 1, vpn1 4 fails at level 0
task automatic build_fault_tables();
    load_word(ROOT_BASE + 32'd12, make_pte(22'h5, F_R));
    load_word(ROOT_BASE + 32'd16, make_pte(22'ha, F_V));
    load_word(BAD_BASE, make_pte(22'h6, F_R | F_X));
    load_word(BAD_BASE + 32'd4, make_pte(22'hb, F_V));
endtask

`endif

// File: testbench/ptw_tb.sv
// Sv32 walker testbench
`timescale 1ns/1ps

module ptw_tb;

    import sv32_pkg::*;

    localparam int unsigned PTE_SIZE_LOG2  = 2;
    localparam int unsigned MEM_WORDS_LOG2 = 14;
    localparam int unsigned DEPTH          = 1 << MEM_WORDS_LOG2;
    localparam int unsigned NUM_TESTS      = 5;
    localparam int unsigned REQS_PER_TEST  = 32;
    // memory fill and reset come first, then 40 cycles per request
    localparam int unsigned CYCLE_LIMIT = DEPTH + 64 + NUM_TESTS * REQS_PER_TEST * 40;
    localparam word_t       SATP_ON     = 32'h8000_0008;

    logic     clk;
    logic     rst_n;
    logic     kill;
    mem_req_t preq;
    logic     preq_ready;
    mem_rsp_t presp;
    mode_t    csr_mode;
    word_t    csr_satp;
    logic     load_en;
    word_t    load_addr;
    word_t    load_data;

    int unsigned cycles = 0;
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned tests_run = 0;

    `include "ptw_model.svh"

    ptw_subsystem #(
        .PTE_SIZE_LOG2  (PTE_SIZE_LOG2),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) ptw_subsystem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .kill       (kill),
        .preq       (preq),
        .preq_ready (preq_ready),
        .presp      (presp),
        .csr_mode   (csr_mode),
        .csr_satp   (csr_satp),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic run_access(input logic wen, input word_t addr, input word_t wdata,
                              input logic expect_rsp, output word_t rdata,
                              output logic got_rsp);
        int unsigned wait_cnt;
        preq.valid = 1'b1;
        preq.wen   = wen;
        preq.addr  = addr;
        preq.wdata = wdata;
        @(negedge clk);
        while (!preq_ready) @(negedge clk);
        @(posedge clk);
        #1;
        preq.valid = 1'b0;
        rdata      = '0;
        got_rsp    = 1'b0;
        wait_cnt   = 0;
        if (expect_rsp) begin
            while (!got_rsp && wait_cnt < 100) begin
                @(negedge clk);
                if (presp.valid) begin
                    got_rsp = 1'b1;
                    rdata   = presp.rdata;
                end
                wait_cnt++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic do_read(input word_t va);
        word_t exp;
        word_t got;
        logic  seen;
        exp = shadow_mem[word_index(translate(va))];
        run_access(1'b0, va, '0, 1'b1, got, seen);
        if (!seen) begin
            errors++;
            $display("no response to the read of %h at %0t", va, $time);
        end else begin
            check_word("presp.rdata", got, exp);
        end
    endtask

    // translated writes still pulse presp, bare writes do not
    task automatic do_write(input word_t va, input word_t data);
        word_t got;
        logic  seen;
        logic  on;
        on = translation_on();
        shadow_mem[word_index(translate(va))] = data;
        run_access(1'b1, va, data, on, got, seen);
        if (on && !seen) begin
            errors++;
            $display("no completion pulse for the write to %h at %0t", va, $time);
        end
    endtask

    task automatic report_test(input string name, input int unsigned err_before);
        tests_run++;
        $display("test %0s: %0s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    // kill partway through a walk, walker must drop back to idle
    task automatic kill_walk(input word_t va);
        logic seen;
        preq.valid = 1'b1;
        preq.wen   = 1'b0;
        preq.addr  = va;
        @(negedge clk);
        while (!preq_ready) @(negedge clk);
        @(posedge clk);
        #1;
        preq.valid = 1'b0;
        repeat (1 + next_rand() % 6) @(posedge clk);
        #1;
        kill = 1'b1;
        @(posedge clk);
        #1;
        kill = 1'b0;
        @(negedge clk);
        checks++;
        if (!preq_ready) begin
            errors++;
            $display("preq_ready still low one cycle after kill at %0t", $time);
        end
        checks++;
        seen = presp.valid;
        // past the point where an unkilled walk would finish
        repeat (12) begin
            @(negedge clk);
            seen = seen | presp.valid;
        end
        if (seen) begin
            errors++;
            $display("presp.valid pulsed after a killed walk at %0t", $time);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        int unsigned err_before;
        word_t       r;
        word_t       va;
        rst_n     = 1'b0;
        kill      = 1'b0;
        preq      = '0;
        csr_mode  = M_MODE;
        csr_satp  = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fill_memory();

        // bare and machine mode, addresses pass unchanged
        err_before = errors;
        csr_mode   = M_MODE;
        csr_satp   = SATP_ON;
        for (int i = 0; i < 16; i++) begin
            if (i == 8) begin
                csr_mode = S_MODE;
                csr_satp = 32'h0000_0008;
            end
            r  = next_rand();
            va = {r[31:2], 2'b00};
            if (r[0]) begin
                do_write(va, next_rand());
            end
            do_read(va);
        end
        report_test("bare", err_before);

        build_4k_tables();
        build_megapage();
        build_fault_tables();
        csr_mode = S_MODE;
        csr_satp = SATP_ON;

        // megapage reads
        err_before = errors;
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            do_read({10'h002, r[21:2], 2'b00});
        end
        report_test("megapage", err_before);

        // 4K pages, writes read back
        err_before = errors;
        for (int i = 0; i < 16; i++) begin
            r  = next_rand();
            va = {10'h001, 8'h00, r[1:0], r[13:4], 2'b00};
            if (r[20]) begin
                do_write(va, next_rand());
            end
            do_read(va);
        end
        report_test("4k_pages", err_before);

        // failed walks land on address 0
        err_before = errors;
        for (int i = 0; i < 32; i++) begin
            r = next_rand();
            case (i % 3)
                0: va = {10'h003, r[21:2], 2'b00};
                1: va = {10'h004, 10'h000, r[11:2], 2'b00};
                default: va = {10'h004, 10'h001, r[11:2], 2'b00};
            endcase
            if (i % 4 == 3) begin
                do_write(va, next_rand());
            end else begin
                do_read(va);
            end
        end
        report_test("failed_walks", err_before);

        // kill, then a clean translated read
        err_before = errors;
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            kill_walk({10'h001, 8'h00, r[1:0], r[13:4], 2'b00});
            r = next_rand();
            do_read({10'h001, 8'h00, r[1:0], r[13:4], 2'b00});
        end
        report_test("kill", err_before);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+testbench
design/sv32_pkg.sv
design/main_memory.sv
design/page_table_walker.sv
design/ptw_subsystem.sv
testbench/ptw_tb.sv
